//--- Bender.yml
package:
  name: npc_core

sources:
  - src/npc_pkg.sv
  - src/bus_arbiter.sv
  - src/fetch_unit.sv
  - src/decoder.sv
  - src/exec_unit.sv
  - src/lsu.sv
  - src/regfile.sv
  - src/npc_core.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_npc_core.sv

//--- compile.f
src/npc_pkg.sv
src/bus_arbiter.sv
src/fetch_unit.sv
src/decoder.sv
src/exec_unit.sv
src/lsu.sv
src/regfile.sv
src/npc_core.sv
testbench/tb_clk_gen.sv
testbench/tb_npc_core.sv

//--- src/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter import npc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  mem_req_t fetch_req_i,
    input  mem_req_t lsu_req_i,
    output mem_rsp_t fetch_rsp_o,
    output mem_rsp_t lsu_rsp_o,
    output mem_req_t mem_req_o,
    input  mem_rsp_t mem_rsp_i
);

    logic busy_q;
    logic owner_lsu_q;
    logic sel_lsu;

    // lsu wins when the bus is free and keeps the grant until ready
    assign sel_lsu   = busy_q ? owner_lsu_q : lsu_req_i.valid;
    assign mem_req_o = sel_lsu ? lsu_req_i : fetch_req_i;

    always_comb begin
        fetch_rsp_o       = mem_rsp_i;
        lsu_rsp_o         = mem_rsp_i;
        fetch_rsp_o.ready = mem_rsp_i.ready && busy_q && !owner_lsu_q;
        lsu_rsp_o.ready   = mem_rsp_i.ready && busy_q && owner_lsu_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            owner_lsu_q <= 1'b0;
        end else if (!busy_q) begin
            if (mem_req_o.valid) begin
                busy_q      <= 1'b1;
                owner_lsu_q <= sel_lsu;
            end
        end else if (mem_rsp_i.ready) begin
            busy_q <= 1'b0;
        end
    end

    // every bus ready lands on exactly one peer
    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rsp_i.ready |-> (fetch_rsp_o.ready ^ lsu_rsp_o.ready));

    // both peers must hold their request while it waits for ready
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_o.valid && !mem_rsp_i.ready |=> $stable(mem_req_o));

endmodule

`default_nettype wire

//--- src/decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder import npc_pkg::*; (
    input  logic [XLEN-1:0] inst_i,
    output decoded_t        dec_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // immediate formats
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        dec_o.op  = OP_ILLEGAL;
        // low four bits of each register field
        dec_o.rd  = inst_i[10:7];
        dec_o.rs1 = inst_i[18:15];
        dec_o.rs2 = inst_i[23:20];
        dec_o.imm = imm_i;
        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    dec_o.op = OP_ADDI;
                end
            end
            OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    dec_o.op = OP_ADD;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    dec_o.op = OP_SUB;
                end
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    dec_o.op = OP_LW;
                end
            end
            OPC_STORE: begin
                dec_o.imm = imm_s;
                if (funct3 == 3'b010) begin
                    dec_o.op = OP_SW;
                end
            end
            OPC_BRANCH: begin
                dec_o.imm = imm_b;
                if (funct3 == 3'b000) begin
                    dec_o.op = OP_BEQ;
                end
            end
            OPC_JAL: begin
                dec_o.imm = imm_j;
                dec_o.op  = OP_JAL;
            end
            OPC_SYSTEM: begin
                if (inst_i == INST_EBREAK) begin
                    dec_o.op = OP_EBREAK;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- src/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit import npc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  fetch_pkt_t            pkt_i,
    output logic                  consume_o,
    output redirect_t             redirect_o,
    output logic                  halt_o,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic                  wr_en_o,
    output logic [REG_ADDR_W-1:0] wr_addr_o,
    output logic [XLEN-1:0]       wr_data_o,
    output logic                  lsu_valid_o,
    output logic                  lsu_wen_o,
    output logic [XLEN-1:0]       lsu_addr_o,
    output logic [XLEN-1:0]       lsu_wdata_o,
    input  logic                  lsu_done_i,
    input  logic [XLEN-1:0]       lsu_rdata_i
);

    decoded_t        dec;
    logic            halt_q;
    logic            active;
    logic [XLEN-1:0] link_pc;
    logic [XLEN-1:0] target_pc;

    decoder i_decoder (
        .inst_i (pkt_i.inst),
        .dec_o  (dec       )
    );

    assign active      = pkt_i.valid && !halt_q;
    assign link_pc     = pkt_i.pc + XLEN'(4);
    assign target_pc   = pkt_i.pc + dec.imm;
    assign rs1_addr_o  = dec.rs1;
    assign rs2_addr_o  = dec.rs2;
    assign wr_addr_o   = dec.rd;
    // rs1 + imm, shared by ADDI and the load/store address
    assign lsu_addr_o  = rs1_data_i + dec.imm;
    assign lsu_wdata_o = rs2_data_i;
    assign halt_o      = halt_q;

    always_comb begin
        consume_o   = 1'b0;
        redirect_o  = '{valid: 1'b0, pc: target_pc};
        wr_en_o     = 1'b0;
        wr_data_o   = lsu_addr_o;
        lsu_valid_o = 1'b0;
        lsu_wen_o   = 1'b0;
        if (active) begin
            case (dec.op)
                OP_ADDI: begin
                    consume_o = 1'b1;
                    wr_en_o   = 1'b1;
                end
                OP_ADD, OP_SUB: begin
                    consume_o = 1'b1;
                    wr_en_o   = 1'b1;
                    wr_data_o = (dec.op == OP_SUB) ? rs1_data_i - rs2_data_i
                                                   : rs1_data_i + rs2_data_i;
                end
                OP_LW: begin
                    lsu_valid_o = 1'b1;
                    consume_o   = lsu_done_i;
                    wr_en_o     = lsu_done_i;
                    wr_data_o   = lsu_rdata_i;
                end
                OP_SW: begin
                    lsu_valid_o = 1'b1;
                    lsu_wen_o   = 1'b1;
                    consume_o   = lsu_done_i;
                end
                OP_BEQ: begin
                    consume_o        = 1'b1;
                    redirect_o.valid = (rs1_data_i == rs2_data_i);
                end
                OP_JAL: begin
                    consume_o        = 1'b1;
                    wr_en_o          = 1'b1;
                    wr_data_o        = link_pc;
                    redirect_o.valid = 1'b1;
                end
                // ebreak and unknown ops stay in the buffer
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            halt_q <= 1'b0;
        end else if (active && (dec.op == OP_EBREAK || dec.op == OP_ILLEGAL)) begin
            halt_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import npc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       consume_i,
    input  redirect_t  redirect_i,
    input  logic       halt_i,
    output fetch_pkt_t pkt_o,
    output mem_req_t   bus_req_o,
    input  mem_rsp_t   bus_rsp_i
);

    fetch_state_e    state_q;
    fetch_pkt_t      buf_q;
    logic [XLEN-1:0] fetch_pc_q;
    logic [XLEN-1:0] next_pc_q;
    logic [XLEN-1:0] start_pc;
    logic            issue_now;

    assign start_pc  = redirect_i.valid ? redirect_i.pc : next_pc_q;
    // early request in the cycle the buffer drains
    assign issue_now = (state_q == FETCH_IDLE) && consume_i && !halt_i;

    assign bus_req_o = '{
        valid: issue_now || (state_q != FETCH_IDLE),
        wen:   1'b0,
        addr:  issue_now ? start_pc : fetch_pc_q,
        wdata: '0
    };
    assign pkt_o = buf_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= FETCH_IDLE;
            buf_q.valid <= 1'b0;
            next_pc_q   <= RESET_PC;
        end else begin
            if (consume_i) begin
                buf_q.valid <= 1'b0;
            end
            case (state_q)
                FETCH_IDLE: begin
                    next_pc_q <= start_pc;
                    if (!halt_i && (consume_i || !buf_q.valid)) begin
                        state_q    <= FETCH_WAIT;
                        fetch_pc_q <= start_pc;
                    end
                end
                FETCH_WAIT: begin
                    if (redirect_i.valid) begin
                        next_pc_q <= redirect_i.pc;
                        state_q   <= bus_rsp_i.ready ? FETCH_IDLE : FETCH_DROP;
                    end else if (bus_rsp_i.ready) begin
                        next_pc_q <= fetch_pc_q + XLEN'(4);
                        state_q   <= FETCH_IDLE;
                        buf_q     <= '{valid: 1'b1, pc: fetch_pc_q, inst: bus_rsp_i.rdata};
                    end
                end
                FETCH_DROP: begin
                    // stale word, thrown away
                    if (bus_rsp_i.ready) begin
                        state_q <= FETCH_IDLE;
                    end
                end
                default: state_q <= FETCH_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/lsu.sv
`timescale 1ns/1ns
`default_nettype none

module lsu import npc_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            valid_i,
    input  logic            wen_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,
    output logic            done_o,
    output logic [XLEN-1:0] rdata_o,
    output mem_req_t        bus_req_o,
    input  mem_rsp_t        bus_rsp_i
);

    lsu_state_e      state_q;
    logic            done_q;
    logic [XLEN-1:0] rdata_q;

    // address and data come straight from exec, held until done
    assign bus_req_o = '{
        valid: (state_q == LSU_WAIT),
        wen:   wen_i,
        addr:  addr_i,
        wdata: wdata_i
    };
    assign done_o  = done_q;
    assign rdata_o = rdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= LSU_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                LSU_IDLE: begin
                    // skip the cycle where exec still sees the finished access
                    if (valid_i && !done_q) begin
                        state_q <= LSU_WAIT;
                    end
                end
                LSU_WAIT: begin
                    if (bus_rsp_i.ready) begin
                        state_q <= LSU_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LSU_WAIT && bus_rsp_i.ready) begin
            rdata_q <= bus_rsp_i.rdata;
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_i |-> (addr_i[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- src/npc_core.sv
`timescale 1ns/1ns
`default_nettype none

module npc_core import npc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    output mem_req_t mem_req_o,
    input  mem_rsp_t mem_rsp_i,
    output logic     halt_o
);

    // ==============================
    // internal wires
    // ==============================
    mem_req_t              fetch_req;
    mem_rsp_t              fetch_rsp;
    mem_req_t              lsu_req;
    mem_rsp_t              lsu_rsp;
    fetch_pkt_t            pkt;
    logic                  consume;
    redirect_t             redirect;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;
    logic                  lsu_valid;
    logic                  lsu_wen;
    logic [XLEN-1:0]       lsu_addr;
    logic [XLEN-1:0]       lsu_wdata;
    logic                  lsu_done;
    logic [XLEN-1:0]       lsu_rdata;

    // ==============================
    // submodules
    // ==============================
    fetch_unit i_fetch_unit (
        .clk        (clk      ),
        .rst_n_i    (rst_n_i  ),
        .consume_i  (consume  ),
        .redirect_i (redirect ),
        .halt_i     (halt_o   ),
        .pkt_o      (pkt      ),
        .bus_req_o  (fetch_req),
        .bus_rsp_i  (fetch_rsp)
    );

    exec_unit i_exec_unit (
        .clk         (clk      ),
        .rst_n_i     (rst_n_i  ),
        .pkt_i       (pkt      ),
        .consume_o   (consume  ),
        .redirect_o  (redirect ),
        .halt_o      (halt_o   ),
        .rs1_addr_o  (rs1_addr ),
        .rs2_addr_o  (rs2_addr ),
        .rs1_data_i  (rs1_data ),
        .rs2_data_i  (rs2_data ),
        .wr_en_o     (wr_en    ),
        .wr_addr_o   (wr_addr  ),
        .wr_data_o   (wr_data  ),
        .lsu_valid_o (lsu_valid),
        .lsu_wen_o   (lsu_wen  ),
        .lsu_addr_o  (lsu_addr ),
        .lsu_wdata_o (lsu_wdata),
        .lsu_done_i  (lsu_done ),
        .lsu_rdata_i (lsu_rdata)
    );

    lsu i_lsu (
        .clk       (clk      ),
        .rst_n_i   (rst_n_i  ),
        .valid_i   (lsu_valid),
        .wen_i     (lsu_wen  ),
        .addr_i    (lsu_addr ),
        .wdata_i   (lsu_wdata),
        .done_o    (lsu_done ),
        .rdata_o   (lsu_rdata),
        .bus_req_o (lsu_req  ),
        .bus_rsp_i (lsu_rsp  )
    );

    regfile i_regfile (
        .clk        (clk     ),
        .rst_n_i    (rst_n_i ),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wr_addr_i  (wr_addr ),
        .wr_en_i    (wr_en   ),
        .wr_data_i  (wr_data ),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    bus_arbiter i_bus_arbiter (
        .clk         (clk      ),
        .rst_n_i     (rst_n_i  ),
        .fetch_req_i (fetch_req),
        .lsu_req_i   (lsu_req  ),
        .fetch_rsp_o (fetch_rsp),
        .lsu_rsp_o   (lsu_rsp  ),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i)
    );

endmodule

`default_nettype wire

//--- src/npc_pkg.sv
`default_nettype none

package npc_pkg;

    // ==============================
    // widths and reset values
    // ==============================
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 4;
    localparam int unsigned NUM_REGS   = 16;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [XLEN-1:0] INST_EBREAK = 32'h0010_0073;

    // ==============================
    // types
    // ==============================
    typedef enum logic [3:0] {
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_JAL,
        OP_EBREAK,
        OP_ILLEGAL
    } op_e;

    typedef struct packed {
        logic            valid;
        logic            wen;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
    } decoded_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

    typedef enum logic {
        LSU_IDLE,
        LSU_WAIT
    } lsu_state_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_DROP
    } fetch_state_e;

endpackage

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile import npc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [REG_ADDR_W-1:0] wr_addr_i,
    input  logic                  wr_en_i,
    input  logic [XLEN-1:0]       wr_data_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 hardwired
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

//--- testbench/npc_testdata.txt
# P <word address hex> <instruction hex>, S <store address hex> <store data hex>
# H <number of stores expected before the core halts, decimal>
P 00000000 00500093
P 00000004 00700113
P 00000008 002081b3
P 0000000c 40208233
P 00000010 08302023
P 00000014 08402223
P 00000018 08002283
P 0000001c 08502423
P 00000020 00208463
P 00000024 08102623
P 00000028 00518463
P 0000002c 08202823
P 00000030 0080036f
P 00000034 08202a23
P 00000038 08602c23
P 0000003c 00900013
P 00000040 08002e23
P 00000044 00100073
P 00000048 0a102023
# stores in program order
S 00000080 0000000c
S 00000084 fffffffe
S 00000088 0000000c
S 0000008c 00000005
S 00000098 00000034
S 0000009c 00000000
H 6

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int unsigned PERIOD_NS    = 8;
    localparam int unsigned RESET_CYCLES = 2;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_npc_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_npc_core import npc_pkg::*; ();

    // ==============================
    // run limits
    // ==============================
    localparam int unsigned PERIOD_NS     = 8;
    localparam int unsigned RESET_CYCLES  = 2;
    localparam int unsigned MAX_ACCESSES  = 200;
    // request cycle, up to 4 wait states, ready cycle
    localparam int unsigned ACCESS_CYCLES = 6;
    localparam int unsigned WATCHDOG_NS   =
        (RESET_CYCLES + MAX_ACCESSES * ACCESS_CYCLES) * PERIOD_NS;
    localparam int unsigned DRAIN_CYCLES  = 20;
    localparam int unsigned MEM_WORDS     = 64;
    localparam string       TESTDATA_PATH = "testbench/npc_testdata.txt";

    logic            clk;
    logic            rst_n;
    mem_req_t        mem_req;
    mem_rsp_t        mem_rsp;
    logic            halt;
    logic [XLEN-1:0] mem [MEM_WORDS];
    mem_req_t        exp_stores [$];
    int              exp_count   = 0;
    int              stores_seen = 0;
    int              error_count = 0;
    logic [31:0]     lfsr_q      = 32'h71400a4a;

    tb_clk_gen i_clk_gen (
        .clk_o   (clk  ),
        .rst_n_o (rst_n)
    );

    npc_core i_npc_core (
        .clk       (clk    ),
        .rst_n_i   (rst_n  ),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp),
        .halt_o    (halt   )
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int unsigned n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            bits   = {bits[30:0], lfsr_q[0]};
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        error_count++;
    endtask

    task automatic check_fetch(input mem_req_t got, input logic [XLEN-1:0] exp_addr);
        if (got.wen !== 1'b0 || got.addr !== exp_addr) begin
            $display("error %0t: first access wen %b addr %h, expected a read of %h",
                     $time, got.wen, got.addr, exp_addr);
            error_count++;
        end
    endtask

    task automatic check_store(input mem_req_t got);
        mem_req_t exp;
        stores_seen++;
        if (exp_stores.size() == 0) begin
            note_failure($sformatf("store of %h to %h was not expected", got.wdata, got.addr));
        end else begin
            exp = exp_stores.pop_front();
            if (got.addr !== exp.addr || got.wdata !== exp.wdata) begin
                $display("error %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                         stores_seen, got.wdata, got.addr, exp.wdata, exp.addr);
                error_count++;
            end
        end
    endtask

    task automatic check_halt(input logic got, input int stores);
        if (got !== 1'b1) begin
            $display("error %0t: halt_o is %b, expected 1", $time, got);
            error_count++;
        end
        if (stores != exp_count) begin
            $display("error %0t: %0d stores seen, expected %0d", $time, stores, exp_count);
            error_count++;
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d, stores seen: %0d, stores expected: %0d",
                 error_count, stores_seen, exp_count);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        print_counts();
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic load_testdata(output bit ok);
        int          fd;
        int          code;
        string       line;
        logic [31:0] addr;
        logic [31:0] data;
        mem_req_t    exp;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hbad0_0000 | (i << 2);
        end
        fd = $fopen(TESTDATA_PATH, "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    case (line.getc(0))
                        "P": begin
                            code = $sscanf(line, "P %h %h", addr, data);
                            mem[addr[7:2]] = data;
                        end
                        "S": begin
                            code = $sscanf(line, "S %h %h", addr, data);
                            exp  = '{valid: 1'b1, wen: 1'b1, addr: addr, wdata: data};
                            exp_stores.push_back(exp);
                        end
                        "H": code = $sscanf(line, "H %d", exp_count);
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // ==============================
    // memory model
    // ==============================
    initial begin : mem_model
        mem_req_t    req;
        logic [31:0] rnd;
        logic        halt_idle;
        logic        first_access;
        mem_rsp      = '0;
        halt_idle    = 1'b0;
        first_access = 1'b1;
        forever begin
            @(negedge clk);
            mem_rsp.ready = 1'b0;
            if (mem_req.valid === 1'b1) begin
                if (halt_idle) begin
                    note_failure("the core started a bus access after it had halted");
                end
                draw_bits(2, rnd);
                repeat (1 + int'(rnd[1:0])) @(negedge clk);
                req = mem_req;
                if (first_access) begin
                    check_fetch(req, RESET_PC);
                    first_access = 1'b0;
                end
                if (req.addr[XLEN-1:8] != '0) begin
                    note_failure($sformatf("access to %h is outside the memory", req.addr));
                end
                mem_rsp.rdata = mem[req.addr[7:2]];
                if (req.wen) begin
                    if (halt === 1'b1) begin
                        note_failure("a store reached the bus after the core halted");
                    end
                    check_store(req);
                    mem[req.addr[7:2]] = req.wdata;
                end
                mem_rsp.ready = 1'b1;
            end else if (halt === 1'b1) begin
                halt_idle = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("timeout: the core did not halt within the bus access budget");
    end

    initial begin : main_seq
        bit          ok;
        int unsigned drained;
        load_testdata(ok);
        if (!ok) begin
            abort_run("could not open the test data file");
        end else begin
            // outputs idle while reset is held
            @(posedge clk);
            @(negedge clk);
            if (mem_req.valid !== 1'b0 || halt !== 1'b0) begin
                $display("error %0t: valid %b halt %b during reset, expected 0 and 0",
                         $time, mem_req.valid, halt);
                error_count++;
            end
            while (halt !== 1'b1) begin
                @(negedge clk);
            end
            // halt_o has to hold while the bus stays quiet
            drained = 0;
            while (drained < DRAIN_CYCLES && halt === 1'b1) begin
                @(negedge clk);
                drained++;
            end
            check_halt(halt, stores_seen);
            print_counts();
            if (error_count == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
